//--- Bender.yml
package:
  name: move_order_unit

export_include_dirs:
  - include

sources:
  - verilog/move_order_pkg.sv
  - verilog/stream_sorter.sv
  - verilog/sorter_pool.sv
  - verilog/move_stack_ram.sv
  - verilog/move_order_unit.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/move_order_checker.sv
      - tb/move_order_tb.sv

//--- build.f
+incdir+include
verilog/move_order_pkg.sv
verilog/stream_sorter.sv
verilog/sorter_pool.sv
verilog/move_stack_ram.sv
verilog/move_order_unit.sv
tb/tb_clock.sv
tb/move_order_checker.sv
tb/move_order_tb.sv

//--- include/move_order_config.svh
`ifndef MOVE_ORDER_CONFIG_SVH
`define MOVE_ORDER_CONFIG_SVH

// entries per move list and per sorter
`define MO_MAX_MOVES 8

// depth regions in the move stack
`define MO_MAX_DEPTH 4

// drain ordering is written for exactly two
`define MO_NUM_SORTERS 2

`define MO_RD_LATENCY 2 // cycles from read address to rd_move

`endif

//--- tb/move_order_checker.sv
`timescale 1ns/1ps
`include "move_order_config.svh"

module move_order_checker (
    input logic                      clk_in,
    input logic                      rst_in,
    input logic                      list_start_in,
    input move_order_pkg::depth_t    depth_in,
    input move_order_pkg::move_t     move_in,
    input move_order_pkg::eval_t     eval_in,
    input logic                      move_valid_in,
    input logic                      list_end_in,
    input move_order_pkg::depth_t    rd_depth_in,
    input move_order_pkg::move_idx_t rd_idx_in,
    input logic                      rd_req,
    input move_order_pkg::move_t     rd_exp,
    input logic                      ready_out,
    input logic                      list_done_out,
    input move_order_pkg::depth_t    done_depth_out,
    input move_order_pkg::move_cnt_t done_len_out,
    input move_order_pkg::move_t     rd_move_out
);
    localparam int SLOTS = `MO_MAX_DEPTH * `MO_MAX_MOVES;

    int                 error_count = 0;
    int                 cycle = 0;
    int                 busy = 0; // sorters collecting or holding a closed list
    logic               open = 1'b0;
    int                 open_depth = 0;
    logic [15:0]        open_moves [$];
    logic signed [15:0] open_evals [$];
    int                 closed_depth [$];
    int                 closed_len [$];
    int                 closed_end [$];
    bit                 closed_fast [$]; // empty list closed with nothing ahead
    logic [15:0]        closed_moves [$];
    logic [15:0]        stack_mem [SLOTS];
    bit                 stack_valid [SLOTS];
    logic [15:0]        rd_model [$];
    bit                 rd_known [$];
    logic [15:0]        rd_vector [$];
    int                 rd_due [$];

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        error_count++;
        $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
    endtask

    // new entry bubbles ahead of strictly lower evals only
    task automatic insert_move(input logic [15:0] mv, input logic signed [15:0] ev);
        int i;
        if (open_moves.size() < `MO_MAX_MOVES) begin
            open_moves.push_back(mv);
            open_evals.push_back(ev);
            i = open_moves.size() - 1;
            while (i > 0 && open_evals[i-1] < ev) begin
                open_moves[i]   = open_moves[i-1];
                open_evals[i]   = open_evals[i-1];
                open_moves[i-1] = mv;
                open_evals[i-1] = ev;
                i--;
            end
        end
    endtask

    task automatic check_done();
        int depth;
        int len;
        int lat;
        bit fast;
        if (closed_len.size() == 0) begin
            error_count++;
            $display("%0t: list_done_out pulsed while no closed list was waiting", $time);
        end else begin
            depth = closed_depth.pop_front();
            len   = closed_len.pop_front();
            lat   = cycle - closed_end.pop_front();
            fast  = closed_fast.pop_front();
            if (done_depth_out !== move_order_pkg::depth_t'(depth)) begin
                report_mismatch("done_depth_out", depth, done_depth_out);
            end
            if (done_len_out !== move_order_pkg::move_cnt_t'(len)) begin
                report_mismatch("done_len_out", len, done_len_out);
            end
            if ((fast && lat != 1) || (len > 0 && lat < len + 2)) begin
                error_count++;
                $display("%0t: list at depth %0d reported done %0d cycles after its end",
                         $time, depth, lat);
            end
            for (int k = 0; k < len; k++) begin
                stack_mem[depth * `MO_MAX_MOVES + k]   = closed_moves.pop_front();
                stack_valid[depth * `MO_MAX_MOVES + k] = 1'b1;
            end
            busy--;
        end
    endtask

    always @(posedge clk_in) begin : sample
        logic        exp_ready;
        logic [15:0] mdl;
        logic [15:0] vec;
        bit          known;
        int          addr;
        if (rst_in) begin
            open = 1'b0;
            busy = 0;
            open_moves.delete();
            open_evals.delete();
            closed_depth.delete();
            closed_len.delete();
            closed_end.delete();
            closed_fast.delete();
            closed_moves.delete();
            rd_due.delete();
        end else begin
            cycle++;
            // a finished sorter is already free while done is high
            exp_ready = !open && (busy - ((list_done_out === 1'b1) ? 1 : 0)) < `MO_NUM_SORTERS;
            if (ready_out !== exp_ready) begin
                report_mismatch("ready_out", exp_ready, ready_out);
            end
            if (list_done_out !== 1'b0) begin
                check_done();
            end

            while (rd_due.size() > 0 && rd_due[0] == cycle) begin
                void'(rd_due.pop_front());
                mdl   = rd_model.pop_front();
                known = rd_known.pop_front();
                vec   = rd_vector.pop_front();
                if (known && rd_move_out !== mdl) begin
                    report_mismatch("rd_move_out", mdl, rd_move_out);
                end
                if (rd_move_out !== vec) begin
                    report_mismatch("rd_move_out (vector)", vec, rd_move_out);
                end
            end
            if (rd_req) begin
                addr = int'(rd_depth_in) * `MO_MAX_MOVES + int'(rd_idx_in);
                rd_model.push_back(stack_mem[addr]);
                rd_known.push_back(stack_valid[addr]);
                rd_vector.push_back(rd_exp);
                rd_due.push_back(cycle + `MO_RD_LATENCY);
            end

            if (list_start_in && exp_ready) begin
                open       = 1'b1;
                open_depth = int'(depth_in);
                busy++;
                open_moves.delete();
                open_evals.delete();
            end
            if (move_valid_in && open) begin
                insert_move(move_in, eval_in);
            end
            if (list_end_in && open) begin
                open = 1'b0;
                closed_depth.push_back(open_depth);
                closed_len.push_back(open_moves.size());
                closed_end.push_back(cycle);
                closed_fast.push_back(open_moves.size() == 0 && closed_len.size() == 1);
                foreach (open_moves[i]) begin
                    closed_moves.push_back(open_moves[i]);
                end
            end
        end
    end

endmodule

//--- tb/move_order_tb.sv
`timescale 1ns/1ps
`include "move_order_config.svh"

module move_order_tb;
    localparam int CYCLES_PER_LINE = `MO_MAX_MOVES + 20;
    localparam int WAIT_LIMIT      = 4 * CYCLES_PER_LINE; // for ready or done

    logic                      clk_in;
    logic                      rst_in;
    logic                      list_start_in;
    move_order_pkg::depth_t    depth_in;
    move_order_pkg::move_t     move_in;
    move_order_pkg::eval_t     eval_in;
    logic                      move_valid_in;
    logic                      list_end_in;
    move_order_pkg::depth_t    rd_depth_in;
    move_order_pkg::move_idx_t rd_idx_in;
    logic                      ready_out;
    logic                      list_done_out;
    move_order_pkg::depth_t    done_depth_out;
    move_order_pkg::move_cnt_t done_len_out;
    move_order_pkg::move_t     rd_move_out;
    logic                      rd_req; // read address valid this cycle
    move_order_pkg::move_t     rd_exp;

    string  lines [$];
    int     tb_errors = 0;
    int     ends_issued = 0;
    int     dones_seen = 0;
    int     watchdog_cycles = 0;
    integer seed;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk_out(clk_in));

    move_order_unit DUT (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .list_start_in (list_start_in),
        .depth_in      (depth_in),
        .move_in       (move_in),
        .eval_in       (eval_in),
        .move_valid_in (move_valid_in),
        .list_end_in   (list_end_in),
        .rd_depth_in   (rd_depth_in),
        .rd_idx_in     (rd_idx_in),
        .ready_out     (ready_out),
        .list_done_out (list_done_out),
        .done_depth_out(done_depth_out),
        .done_len_out  (done_len_out),
        .rd_move_out   (rd_move_out)
    );

    move_order_checker u_checker (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .list_start_in (list_start_in),
        .depth_in      (depth_in),
        .move_in       (move_in),
        .eval_in       (eval_in),
        .move_valid_in (move_valid_in),
        .list_end_in   (list_end_in),
        .rd_depth_in   (rd_depth_in),
        .rd_idx_in     (rd_idx_in),
        .rd_req        (rd_req),
        .rd_exp        (rd_exp),
        .ready_out     (ready_out),
        .list_done_out (list_done_out),
        .done_depth_out(done_depth_out),
        .done_len_out  (done_len_out),
        .rd_move_out   (rd_move_out)
    );

    always @(posedge clk_in) begin
        if (!rst_in && list_done_out === 1'b1) begin
            dones_seen++;
        end
    end

    task automatic clear_strobes();
        list_start_in = 1'b0;
        move_valid_in = 1'b0;
        list_end_in   = 1'b0;
        rd_req        = 1'b0;
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tb/move_order_vectors.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("cannot open tb/move_order_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic start_list(input logic [31:0] depth);
        int waited;
        waited = 0;
        @(negedge clk_in);
        clear_strobes();
        while (ready_out !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk_in);
            waited++;
        end
        if (ready_out !== 1'b1) begin
            tb_errors++;
            $display("%0t: ready_out stayed low before the list at depth %0d", $time, depth);
        end
        list_start_in = 1'b1;
        depth_in      = move_order_pkg::depth_t'(depth);
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        @(negedge clk_in);
        clear_strobes();
        while (dones_seen < ends_issued && waited < WAIT_LIMIT) begin
            @(negedge clk_in);
            waited++;
        end
        if (dones_seen < ends_issued) begin
            tb_errors++;
            $display("%0t: no list_done_out pulse for %0d closed lists", $time,
                     ends_issued - dones_seen);
        end
    endtask

    task automatic idle_cycles(input int n);
        int count;
        count = (n > 0) ? n : 1 + int'($unsigned($random(seed)) % 4); // 0 means random gap
        repeat (count) begin
            @(negedge clk_in);
            clear_strobes();
        end
    endtask

    task automatic run_line(input string line);
        string       cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          fields;
        a = '0;
        b = '0;
        c = '0;
        fields = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
        case (cmd)
            "start": start_list(a);
            "move": begin
                @(negedge clk_in);
                clear_strobes();
                move_valid_in = 1'b1;
                move_in       = move_order_pkg::move_t'(a[15:0]);
                eval_in       = move_order_pkg::eval_t'(b[15:0]);
            end
            "end": begin
                @(negedge clk_in);
                clear_strobes();
                list_end_in = 1'b1;
                ends_issued++;
            end
            "read": begin
                @(negedge clk_in);
                clear_strobes();
                rd_depth_in = move_order_pkg::depth_t'(a);
                rd_idx_in   = move_order_pkg::move_idx_t'(b);
                rd_exp      = move_order_pkg::move_t'(c[15:0]);
                rd_req      = 1'b1;
            end
            "wait": wait_for_done();
            "idle": idle_cycles(a);
            default: begin
                tb_errors++;
                $display("unknown vector command in line: %s (%0d fields)", line, fields);
            end
        endcase
    endtask

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("%0t: watchdog expired after %0d cycles, the run is stuck", $time,
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        seed          = 32'hfb9535da;
        rst_in        = 1'b1;
        depth_in      = '0;
        move_in       = '0;
        eval_in       = '0;
        rd_depth_in   = '0;
        rd_idx_in     = '0;
        rd_exp        = '0;
        clear_strobes();
        load_vectors();
        watchdog_cycles = lines.size() * CYCLES_PER_LINE;

        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        repeat (`MO_RD_LATENCY + 2) begin
            @(negedge clk_in);
            clear_strobes();
        end
        if (dones_seen != ends_issued) begin
            tb_errors++;
            $display("%0d lists closed but %0d done pulses seen", ends_issued, dones_seen);
        end

        $display("error count: checker %0d, testbench %0d", u_checker.error_count, tb_errors);
        if (u_checker.error_count == 0 && tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb/move_order_vectors.txt
# start depth | move word eval | end | read depth idx expected_word  (all hex)
# wait until every closed list is done | idle cycles, 0 gives a random gap
idle 3
start 1
move 0a1c 0032
move 1234 ff9c
move 0b2d 00c8
move 2345 0032
move 3456 0000
move 4567 fff6
end
wait
read 1 0 0b2d
read 1 1 0a1c
read 1 2 2345
read 1 3 3456
read 1 4 4567
read 1 5 1234
idle 0
start 2
move 0101 0010
move 0202 0100
move 0303 8000
move 0404 7fff
end
start 3
move 0505 fffe
move 0606 0003
end
wait
read 2 0 0404
read 2 1 0202
read 2 2 0101
read 2 3 0303
read 3 0 0606
read 3 1 0505
idle 0
start 1
end
wait
read 1 0 0b2d
read 1 5 1234
idle 0
start 0
move 1001 0005
move 2002 0064
move 3003 ff38
move 4004 0005
move 5005 0190
move 6006 fffb
move 7007 0000
move 8008 0320
move 9009 03e8
move a00a 7000
end
wait
read 0 0 8008
read 0 1 5005
read 0 2 2002
read 0 3 1001
read 0 4 4004
read 0 5 7007
read 0 6 6006
read 0 7 3003
idle 2

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_out
);
    initial begin
        clk_out = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_out = ~clk_out;
        end
    end

endmodule

//--- verilog/move_order_pkg.sv
`include "move_order_config.svh"

package move_order_pkg;

    typedef struct packed {
        logic [5:0] from_sq;
        logic [5:0] to_sq;
        logic [3:0] promo;
    } move_t;

    typedef logic signed [15:0] eval_t;

    // eval with the sign bit inverted, so unsigned compare orders like signed
    typedef logic [15:0] sort_key_t;

    typedef logic [$clog2(`MO_MAX_MOVES)-1:0] move_idx_t;
    typedef logic [$clog2(`MO_MAX_MOVES):0] move_cnt_t; // 0 .. MO_MAX_MOVES
    typedef logic [$clog2(`MO_MAX_DEPTH)-1:0] depth_t;

endpackage

//--- verilog/move_order_unit.sv
`timescale 1ns/1ps
`include "move_order_config.svh"

module move_order_unit (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      list_start_in,
    input  move_order_pkg::depth_t    depth_in,
    input  move_order_pkg::move_t     move_in,
    input  move_order_pkg::eval_t     eval_in,
    input  logic                      move_valid_in,
    input  logic                      list_end_in,
    input  move_order_pkg::depth_t    rd_depth_in,
    input  move_order_pkg::move_idx_t rd_idx_in,
    output logic                      ready_out,
    output logic                      list_done_out,
    output move_order_pkg::depth_t    done_depth_out,
    output move_order_pkg::move_cnt_t done_len_out,
    output move_order_pkg::move_t     rd_move_out
);
    logic                      wr_en;
    move_order_pkg::depth_t    wr_depth;
    move_order_pkg::move_idx_t wr_idx;
    move_order_pkg::move_t     wr_move;

    sorter_pool u_pool (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .list_start_in (list_start_in),
        .depth_in      (depth_in),
        .move_in       (move_in),
        .eval_in       (eval_in),
        .move_valid_in (move_valid_in),
        .list_end_in   (list_end_in),
        .ready_out     (ready_out),
        .list_done_out (list_done_out),
        .done_depth_out(done_depth_out),
        .done_len_out  (done_len_out),
        .wr_en         (wr_en),
        .wr_depth      (wr_depth),
        .wr_idx        (wr_idx),
        .wr_move       (wr_move)
    );

    move_stack_ram #(
        .WIDTH($bits(move_order_pkg::move_t)),
        .DEPTH(`MO_MAX_DEPTH * `MO_MAX_MOVES)
    ) u_stack (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_depth(wr_depth),
        .wr_idx  (wr_idx),
        .wr_move (wr_move),
        .rd_depth(rd_depth_in),
        .rd_idx  (rd_idx_in),
        .rd_move (rd_move_out)
    );

endmodule

//--- verilog/move_stack_ram.sv
`timescale 1ns/1ps
`include "move_order_config.svh"

module move_stack_ram #(
    parameter int WIDTH = $bits(move_order_pkg::move_t),
    parameter int DEPTH = `MO_MAX_DEPTH * `MO_MAX_MOVES
) (
    input  logic                      clk_in,
    input  logic                      wr_en,
    input  move_order_pkg::depth_t    wr_depth,
    input  move_order_pkg::move_idx_t wr_idx,
    input  move_order_pkg::move_t     wr_move,
    input  move_order_pkg::depth_t    rd_depth,
    input  move_order_pkg::move_idx_t rd_idx,
    output move_order_pkg::move_t     rd_move
);
    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] rd_pipe [`MO_RD_LATENCY];
    logic [AW-1:0]    wr_addr;
    logic [AW-1:0]    rd_addr;

    // depth picks a region, index the slot inside it
    assign wr_addr = {wr_depth, wr_idx};
    assign rd_addr = {rd_depth, rd_idx};

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_move;
        end
        rd_pipe[0] <= mem[rd_addr]; // read-first on a same-address write
        for (int k = 1; k < `MO_RD_LATENCY; k++) begin
            rd_pipe[k] <= rd_pipe[k-1];
        end
    end

    assign rd_move = rd_pipe[`MO_RD_LATENCY-1];

endmodule

//--- verilog/sorter_pool.sv
`timescale 1ns/1ps
`include "move_order_config.svh"

module sorter_pool (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      list_start_in,
    input  move_order_pkg::depth_t    depth_in,
    input  move_order_pkg::move_t     move_in,
    input  move_order_pkg::eval_t     eval_in,
    input  logic                      move_valid_in,
    input  logic                      list_end_in,
    output logic                      ready_out,
    output logic                      list_done_out,
    output move_order_pkg::depth_t    done_depth_out,
    output move_order_pkg::move_cnt_t done_len_out,
    output logic                      wr_en,
    output move_order_pkg::depth_t    wr_depth,
    output move_order_pkg::move_idx_t wr_idx,
    output move_order_pkg::move_t     wr_move
);
    localparam int N     = `MO_NUM_SORTERS;
    localparam int SEL_W = $clog2(N);

    move_order_pkg::sort_key_t new_key;
    move_order_pkg::move_t     top_value [N];
    move_order_pkg::move_cnt_t sort_len [N];
    move_order_pkg::depth_t    depth_tag [N];
    move_order_pkg::move_idx_t drain_idx [N];
    logic [N-1:0]              collecting;
    logic [N-1:0]              closed;
    logic [N-1:0]              late_close; // closed while an older list still waited
    logic [N-1:0]              pending;    // closed lists that survive this cycle
    logic [SEL_W-1:0]          open_sel;
    logic [SEL_W-1:0]          drain_sel;
    logic [SEL_W-1:0]          free_sel;
    logic [SEL_W-1:0]          next_drain_sel;
    logic                      draining;
    logic                      free_found;
    logic                      drain_found;
    logic                      list_open;
    logic                      start_ok;
    logic                      end_ok;
    logic                      end_empty;
    logic                      drain_write;
    logic                      drain_last;

    assign new_key = {~eval_in[$high(eval_in)], eval_in[$high(eval_in)-1:0]};

    assign list_open = |collecting;
    assign ready_out = !list_open && free_found;
    assign start_ok  = list_start_in && ready_out;
    assign end_ok    = list_end_in && list_open;

    // empty list with nothing queued ahead finishes right away
    assign end_empty = end_ok && (sort_len[open_sel] == '0) && !move_valid_in
                       && (closed == '0);

    assign drain_write = draining && (sort_len[drain_sel] != '0);
    assign drain_last  = draining && (sort_len[drain_sel] <= move_order_pkg::move_cnt_t'(1));
    assign pending     = closed & ~(N'(drain_last) << drain_sel);

    always_comb begin
        logic [N-1:0] others;

        free_found     = 1'b0;
        free_sel       = '0;
        drain_found    = 1'b0;
        next_drain_sel = '0;
        for (int i = 0; i < N; i++) begin
            others = closed & ~(N'(1) << i);
            if (!free_found && !collecting[i] && !closed[i]) begin
                free_found = 1'b1;
                free_sel   = SEL_W'(i);
            end
            if (!drain_found && closed[i] && (!late_close[i] || others == '0)) begin
                drain_found    = 1'b1; // oldest closed list
                next_drain_sel = SEL_W'(i);
            end
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_sorter
        stream_sorter #(
            .MAX_LEN(`MO_MAX_MOVES)
        ) u_sorter (
            .clk_in       (clk_in),
            .rst_in       (rst_in),
            .key_in       (new_key),
            .value_in     (move_in),
            .valid_in     (move_valid_in && collecting[i]),
            .dequeue_in   (drain_write && (drain_sel == SEL_W'(i))),
            .top_value_out(top_value[i]),
            .len_out      (sort_len[i])
        );
    end

    assign wr_en    = drain_write;
    assign wr_depth = depth_tag[drain_sel];
    assign wr_idx   = drain_idx[drain_sel];
    assign wr_move  = top_value[drain_sel];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            collecting    <= '0;
            closed        <= '0;
            late_close    <= '0;
            open_sel      <= '0;
            drain_sel     <= '0;
            draining      <= 1'b0;
            list_done_out <= 1'b0;
        end else begin
            list_done_out <= end_empty || drain_last;

            if (draining) begin
                if (drain_last) begin
                    draining          <= 1'b0;
                    closed[drain_sel] <= 1'b0;
                    late_close        <= '0; // whatever is left is now the oldest
                end
            end else if (drain_found) begin
                draining  <= 1'b1;
                drain_sel <= next_drain_sel;
            end

            if (start_ok) begin
                collecting[free_sel] <= 1'b1;
                open_sel             <= free_sel;
            end

            if (end_ok) begin
                collecting[open_sel] <= 1'b0;
                if (!end_empty) begin
                    closed[open_sel]     <= 1'b1;
                    late_close[open_sel] <= |pending;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start_ok) begin
            depth_tag[free_sel] <= depth_in;
            drain_idx[free_sel] <= '0;
        end
        if (drain_write) begin
            drain_idx[drain_sel] <= drain_idx[drain_sel] + 1'b1;
        end
        if (end_empty) begin
            done_depth_out <= depth_tag[open_sel];
            done_len_out   <= '0;
        end else if (drain_last) begin
            done_depth_out <= depth_tag[drain_sel];
            done_len_out   <= drain_write ?
                              move_order_pkg::move_cnt_t'(drain_idx[drain_sel]) + 1'b1 : '0;
        end
    end

    // moves only arrive while a list is open
    move_needs_open_list: assert property (@(posedge clk_in) disable iff (rst_in)
        move_valid_in |-> list_open);

    no_nested_start: assert property (@(posedge clk_in) disable iff (rst_in)
        list_start_in |-> !list_open);

endmodule

//--- verilog/stream_sorter.sv
`timescale 1ns/1ps
`include "move_order_config.svh"

module stream_sorter #(
    parameter int MAX_LEN = `MO_MAX_MOVES
) (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  move_order_pkg::sort_key_t key_in,
    input  move_order_pkg::move_t     value_in,
    input  logic                      valid_in,
    input  logic                      dequeue_in,
    output move_order_pkg::move_t     top_value_out,
    output move_order_pkg::move_cnt_t len_out
);
    move_order_pkg::sort_key_t keys [MAX_LEN];
    move_order_pkg::move_t     values [MAX_LEN];
    move_order_pkg::sort_key_t nxt_keys [MAX_LEN];
    move_order_pkg::move_t     nxt_values [MAX_LEN];
    move_order_pkg::move_cnt_t len;
    logic [MAX_LEN-1:0]        keep; // entry stays ahead of the incoming one
    logic                      do_insert;
    logic                      do_dequeue;

    assign do_insert  = valid_in && (len < move_order_pkg::move_cnt_t'(MAX_LEN)); // full drops
    assign do_dequeue = dequeue_in && (len != '0);

    // >= puts a new entry behind equal keys, so ties keep arrival order
    always_comb begin
        for (int i = 0; i < MAX_LEN; i++) begin
            keep[i] = (move_order_pkg::move_cnt_t'(i) < len) && (keys[i] >= key_in);
        end
    end

    always_comb begin
        nxt_keys   = keys;
        nxt_values = values;
        if (do_insert) begin
            if (!keep[0]) begin
                nxt_keys[0]   = key_in;
                nxt_values[0] = value_in;
            end
            for (int i = 1; i < MAX_LEN; i++) begin
                if (!keep[i] && keep[i-1]) begin // insertion point
                    nxt_keys[i]   = key_in;
                    nxt_values[i] = value_in;
                end else if (!keep[i]) begin
                    nxt_keys[i]   = keys[i-1];
                    nxt_values[i] = values[i-1];
                end
            end
        end else if (do_dequeue) begin
            for (int i = 0; i < MAX_LEN - 1; i++) begin
                nxt_keys[i]   = keys[i+1];
                nxt_values[i] = values[i+1];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        keys   <= nxt_keys;
        values <= nxt_values;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            len <= '0;
        end else if (do_insert) begin
            len <= len + 1'b1;
        end else if (do_dequeue) begin
            len <= len - 1'b1;
        end
    end

    assign top_value_out = values[0];
    assign len_out       = len;

    // the pool never feeds the sorter it is draining
    insert_vs_dequeue: assert property (@(posedge clk_in) disable iff (rst_in)
        !(valid_in && dequeue_in));

endmodule
